//--- common/sdram_timing_pkg.sv
package sdram_timing_pkg;

  // All delays are in cycles of a 100 MHz clk

  // Power-up wait, kept short for simulation
  // A real part needs this near 100 us
  localparam int init_wait_cycles = 200;

  // Precharge, refresh and activate periods
  localparam int t_rp_cycles = 2;
  localparam int t_rfc_cycles = 8;
  localparam int t_rcd_cycles = 2;
  localparam int t_mrd_cycles = 2;
  // Write recovery followed by the auto precharge
  localparam int t_wr_rp_cycles = 4;

  localparam int cas_latency = 2;

  // 7.5 us between auto refreshes
  localparam int refresh_interval = 750;
  localparam int delay_count_width = 8;
  localparam int refresh_count_width = 10;
endpackage

//--- common/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // Commands, decoded into the strobes by the pin driver
  typedef enum logic [2:0] {
    cmd_nop,
    cmd_active,
    cmd_read,
    cmd_write,
    cmd_precharge_all,
    cmd_auto_refresh,
    cmd_load_mode
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    st_init,
    st_idle,
    st_wait,
    st_write,
    st_read,
    st_read_wait
  } seq_state_e;

  // Address is bank, row, column from the top down
  localparam int addr_width = 25;
  localparam int row_width = 13;
  localparam int col_width = 10;
  localparam int bank_width = 2;
  localparam int data_width = 16;

  localparam int burst_words = 2;
  localparam int rd_data_width = burst_words * data_width;

  // Single write, standard mode, CL 2, sequential, burst of 2
  localparam logic [row_width-1:0] mode_word = {3'b000, 1'b1, 2'b00, 3'd2, 1'b0, 3'b001};
endpackage

//--- common/sdram_cmd_if.sv
interface sdram_cmd_if import sdram_cmd_pkg::*; ();

  // Next command for the pins, one cycle ahead of the pin register
  sdram_cmd_e cmd;
  logic [bank_width-1:0] ba;
  logic [row_width-1:0] a;
  logic [1:0] dqm;
  logic [data_width-1:0] wdata;
  logic cke;

  modport sequencer (
    output cmd, ba, a, dqm, wdata, cke
  );

  modport pins (
    input cmd, ba, a, dqm, wdata, cke
  );

  // Read capture only needs to spot READ
  modport monitor (input cmd);
endinterface

//--- sdram/sdram_sequencer.sv
module sdram_sequencer
  import sdram_timing_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wr_data,
  input  logic [1:0] byte_en,
  input  logic wr_req,
  input  logic rd_req,
  input  logic rd_done,
  output logic init_complete,
  output logic available,
  output logic ready,
  sdram_cmd_if.sequencer cmd_if
);

  seq_state_e state;
  // Where st_wait goes once the delay runs out
  seq_state_e wait_next;
  logic ready_on_exit;
  logic [delay_count_width-1:0] delay_cnt;
  logic [2:0] init_step;
  logic [refresh_count_width-1:0] refresh_cnt;
  logic refresh_due;
  // Latched request
  logic [col_width-1:0] col_q;
  logic [data_width-1:0] data_q;
  logic [1:0] be_q;

  // Column with A10 set for auto precharge
  logic [row_width-1:0] col_addr;

  function automatic logic [delay_count_width-1:0] dly(input int n);
    return delay_count_width'(n);
  endfunction

  assign refresh_due = refresh_cnt >= refresh_count_width'(refresh_interval);
  assign available = (state == st_idle) && !refresh_due;
  assign col_addr = {{(row_width - col_width - 1){1'b0}}, 1'b1, col_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_init;
      wait_next <= st_idle;
      ready_on_exit <= 1'b0;
      delay_cnt <= dly(init_wait_cycles - 1);
      init_step <= '0;
      refresh_cnt <= '0;
      ready <= 1'b0;
      init_complete <= 1'b0;
      cmd_if.cmd <= cmd_nop;
      cmd_if.cke <= 1'b0;
    end else begin
      // NOP unless a state below issues something
      cmd_if.cmd <= cmd_nop;
      ready <= 1'b0;
      if (state != st_init) begin
        refresh_cnt <= refresh_cnt + 1'b1;
      end

      case (state)
        ////////////////////////////////////////
        // Power-up
        st_init: begin
          if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
          end else begin
            init_step <= init_step + 1'b1;
            case (init_step)
              3'd0: begin
                cmd_if.cke <= 1'b1;
                delay_cnt <= dly(init_wait_cycles - 1);
              end
              3'd1: begin
                // A10 high selects all banks
                cmd_if.cmd <= cmd_precharge_all;
                cmd_if.a <= row_width'(1 << 10);
                delay_cnt <= dly(t_rp_cycles - 1);
              end
              3'd2, 3'd3: begin
                cmd_if.cmd <= cmd_auto_refresh;
                delay_cnt <= dly(t_rfc_cycles - 1);
              end
              3'd4: begin
                cmd_if.cmd <= cmd_load_mode;
                cmd_if.ba <= '0;
                cmd_if.a <= mode_word;
                delay_cnt <= dly(t_mrd_cycles - 1);
              end
              default: begin
                init_complete <= 1'b1;
                state <= st_idle;
              end
            endcase
          end
        end

        ////////////////////////////////////////
        // Idle, refresh has priority
        st_idle: begin
          if (refresh_due) begin
            cmd_if.cmd <= cmd_auto_refresh;
            refresh_cnt <= '0;
            delay_cnt <= dly(t_rfc_cycles - 2);
            wait_next <= st_idle;
            ready_on_exit <= 1'b0;
            state <= st_wait;
          end else if (wr_req || rd_req) begin
            // Open the row, write wins over read
            cmd_if.cmd <= cmd_active;
            cmd_if.ba <= addr[addr_width-1 -: bank_width];
            cmd_if.a <= addr[col_width +: row_width];
            col_q <= addr[col_width-1:0];
            data_q <= wr_data;
            be_q <= byte_en;
            delay_cnt <= dly(t_rcd_cycles - 2);
            wait_next <= wr_req ? st_write : st_read;
            ready_on_exit <= 1'b0;
            state <= st_wait;
          end
        end

        st_wait: begin
          if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
          end else begin
            state <= wait_next;
            ready <= ready_on_exit;
          end
        end

        ////////////////////////////////////////
        // Column commands, bank still set from ACTIVE
        st_write: begin
          cmd_if.cmd <= cmd_write;
          cmd_if.a <= col_addr;
          cmd_if.dqm <= ~be_q;
          cmd_if.wdata <= data_q;
          // Recovery and precharge before done
          delay_cnt <= dly(t_wr_rp_cycles);
          wait_next <= st_idle;
          ready_on_exit <= 1'b1;
          state <= st_wait;
        end

        st_read: begin
          cmd_if.cmd <= cmd_read;
          cmd_if.a <= col_addr;
          cmd_if.dqm <= 2'b00;
          state <= st_read_wait;
        end

        // Capture block reports the last word
        st_read_wait: begin
          if (rd_done) begin
            ready <= 1'b1;
            state <= st_idle;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end
endmodule

//--- sdram/sdram_pin_driver.sv
module sdram_pin_driver
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  sdram_cmd_if.pins cmd_if,
  inout  wire  [data_width-1:0] sdram_dq,
  output logic [row_width-1:0] sdram_a,
  output logic [bank_width-1:0] sdram_ba,
  output logic [1:0] sdram_dqm,
  output logic sdram_cs_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_we_n,
  output logic sdram_cke
);

  // cs_n, ras_n, cas_n, we_n
  logic [3:0] strobes;
  logic dq_oe;
  logic [data_width-1:0] dq_out;

  always_comb begin
    case (cmd_if.cmd)
      cmd_active: strobes = 4'b0011;
      cmd_read: strobes = 4'b0101;
      cmd_write: strobes = 4'b0100;
      cmd_precharge_all: strobes = 4'b0010;
      cmd_auto_refresh: strobes = 4'b0001;
      cmd_load_mode: strobes = 4'b0000;
      default: strobes = 4'b0111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // NOP with chip selected, CKE low, bus released
      {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= 4'b0111;
      sdram_cke <= 1'b0;
      dq_oe <= 1'b0;
    end else begin
      {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= strobes;
      sdram_cke <= cmd_if.cke;
      // Drive only alongside the WRITE strobe
      dq_oe <= (cmd_if.cmd == cmd_write);
    end
  end

  always_ff @(posedge clk) begin
    sdram_a <= cmd_if.a;
    sdram_ba <= cmd_if.ba;
    sdram_dqm <= cmd_if.dqm;
    dq_out <= cmd_if.wdata;
  end

  assign sdram_dq = dq_oe ? dq_out : 'z;
endmodule

//--- sdram/sdram_read_capture.sv
module sdram_read_capture
  import sdram_timing_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic [data_width-1:0] sdram_dq,
  sdram_cmd_if.monitor cmd_if,
  output logic [rd_data_width-1:0] rd_data,
  output logic rd_done
);

  // Cycles since READ left the sequencer, zero when idle
  // Phase 1 is READ on the pins, data follows cas_latency later
  logic [2:0] phase;
  logic beat;
  logic [rd_data_width-1:0] shift_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (cmd_if.cmd == cmd_read) begin
      phase <= 3'd1;
    end else if (rd_done) begin
      phase <= '0;
    end else if (phase != '0) begin
      phase <= phase + 1'b1;
    end
  end

  // A data word is on the bus during these phases
  assign beat = (phase > 3'(cas_latency)) && (phase <= 3'(cas_latency + burst_words));
  assign rd_done = (phase == 3'(cas_latency + burst_words));

  // Shift in from the top so the first word lands low
  always_ff @(posedge clk) begin
    if (beat) begin
      shift_q <= {sdram_dq, shift_q[rd_data_width-1:data_width]};
    end
    // Result holds until the next burst completes
    if (rd_done) begin
      rd_data <= {sdram_dq, shift_q[rd_data_width-1:data_width]};
    end
  end
endmodule

//--- sdram/sdram_ctrl.sv
module sdram_ctrl
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  output logic init_complete,
  // Request port
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wr_data,
  input  logic [1:0] byte_en,
  input  logic wr_req,
  input  logic rd_req,
  output logic available,
  output logic ready,
  output logic [rd_data_width-1:0] rd_data,
  // SDRAM pins
  inout  wire  [data_width-1:0] sdram_dq,
  output logic [row_width-1:0] sdram_a,
  output logic [bank_width-1:0] sdram_ba,
  output logic [1:0] sdram_dqm,
  output logic sdram_cs_n,
  output logic sdram_ras_n,
  output logic sdram_cas_n,
  output logic sdram_we_n,
  output logic sdram_cke
);

  logic rd_done;

  sdram_cmd_if cmd_if ();

  sdram_sequencer i_sequencer (
    .clk(clk), .reset(reset), .addr(addr), .wr_data(wr_data), .byte_en(byte_en),
    .wr_req(wr_req), .rd_req(rd_req), .rd_done(rd_done), .init_complete(init_complete),
    .available(available), .ready(ready), .cmd_if(cmd_if.sequencer)
  );

  sdram_pin_driver i_pin_driver (
    .clk(clk), .reset(reset), .cmd_if(cmd_if.pins), .sdram_dq(sdram_dq),
    .sdram_a(sdram_a), .sdram_ba(sdram_ba), .sdram_dqm(sdram_dqm),
    .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n), .sdram_cas_n(sdram_cas_n),
    .sdram_we_n(sdram_we_n), .sdram_cke(sdram_cke)
  );

  // Capture samples the shared bus directly
  sdram_read_capture i_read_capture (
    .clk(clk), .reset(reset), .sdram_dq(sdram_dq), .cmd_if(cmd_if.monitor),
    .rd_data(rd_data), .rd_done(rd_done)
  );
endmodule

//--- verif/sdram_model.sv
module sdram_model
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic cke,
  input  logic cs_n,
  input  logic ras_n,
  input  logic cas_n,
  input  logic we_n,
  input  logic [bank_width-1:0] ba,
  input  logic [row_width-1:0] a,
  input  logic [1:0] dqm,
  inout  wire  [data_width-1:0] dq
);
  timeunit 1ns;
  timeprecision 100ps;

  // Sparse storage keyed by bank, row, column
  logic [data_width-1:0] mem [int unsigned];
  logic [row_width-1:0] open_row [4];
  logic [1:0] rd_cnt = '0;
  logic [addr_width-1:0] rd_key;
  logic oe = 1'b0;
  logic [data_width-1:0] dout;

  assign dq = oe ? dout : 'z;

  // Unwritten words, pattern over the whole address
  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] k);
    return k[15:0] ^ {k[24:16], k[6:0]} ^ 16'h5a5a;
  endfunction

  function automatic logic [data_width-1:0] read_word(input logic [addr_width-1:0] k);
    return mem.exists(k) ? mem[k] : fill_word(k);
  endfunction

  always @(posedge clk) begin
    logic [addr_width-1:0] k;
    logic [data_width-1:0] old;
    oe <= 1'b0;
    // CL 2, word 0 then the other word of the pair
    if (rd_cnt == 2'd1) begin
      oe <= 1'b1;
      dout <= read_word(rd_key);
      rd_cnt <= 2'd2;
    end else if (rd_cnt == 2'd2) begin
      oe <= 1'b1;
      dout <= read_word({rd_key[addr_width-1:1], ~rd_key[0]});
      rd_cnt <= 2'd0;
    end
    if (cke && !cs_n) begin
      case ({ras_n, cas_n, we_n})
        3'b011: open_row[ba] <= a;
        3'b101: begin
          rd_key <= {ba, open_row[ba], a[col_width-1:0]};
          rd_cnt <= 2'd1;
        end
        3'b100: begin
          k = {ba, open_row[ba], a[col_width-1:0]};
          old = read_word(k);
          // dqm high masks the byte
          mem[k] = {dqm[1] ? old[15:8] : dq[15:8], dqm[0] ? old[7:0] : dq[7:0]};
        end
        default: ;
      endcase
    end
  end
endmodule

//--- verif/sdram_checker.sv
module sdram_checker
  import sdram_timing_pkg::*;
  import sdram_cmd_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic init_complete,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wr_data,
  input  logic [1:0] byte_en,
  input  logic wr_req,
  input  logic rd_req,
  input  logic available,
  input  logic ready,
  input  logic [rd_data_width-1:0] rd_data,
  input  logic cs_n,
  input  logic ras_n,
  input  logic cas_n,
  input  logic we_n,
  output int error_count,
  output int read_count,
  output int refresh_count
);
  timeunit 1ns;
  timeprecision 100ps;

  // Shadow of every accepted write
  logic [data_width-1:0] shadow [int unsigned];
  logic pend_rd = 1'b0;
  logic [addr_width-1:0] pend_addr;
  int gap = 0;

  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] k);
    return k[15:0] ^ {k[24:16], k[6:0]} ^ 16'h5a5a;
  endfunction

  function automatic logic [data_width-1:0] shadow_word(input logic [addr_width-1:0] k);
    return shadow.exists(k) ? shadow[k] : fill_word(k);
  endfunction

  // Requested column low, its pair partner high
  function automatic logic [rd_data_width-1:0] expected_rd_data(input logic [addr_width-1:0] a);
    return {shadow_word({a[addr_width-1:1], ~a[0]}), shadow_word(a)};
  endfunction

  always @(posedge clk) begin
    logic [rd_data_width-1:0] exp;
    logic [data_width-1:0] old;
    if (reset) begin
      error_count = 0;
      read_count = 0;
      refresh_count = 0;
      gap = 0;
      pend_rd = 1'b0;
    end else begin
      if (ready && pend_rd) begin
        exp = expected_rd_data(pend_addr);
        read_count++;
        if (rd_data !== exp) begin
          $display("FAIL %0t rd_data addr %h expected %h actual %h",
                   $time, pend_addr, exp, rd_data);
          error_count++;
        end
      end
      // Accepted request, write wins
      if (available && (wr_req || rd_req)) begin
        pend_rd = !wr_req;
        pend_addr = addr;
        if (wr_req) begin
          old = shadow_word(addr);
          shadow[addr] = {byte_en[1] ? wr_data[15:8] : old[15:8],
                          byte_en[0] ? wr_data[7:0] : old[7:0]};
        end
      end
      // Gap between auto refreshes on the pins
      if (!cs_n && !ras_n && !cas_n && we_n) begin
        refresh_count++;
        gap = 0;
      end else if (init_complete) begin
        gap++;
        if (gap == refresh_interval + 16) begin
          $display("Auto refresh missing for %0d cycles at %0t", gap, $time);
          error_count++;
        end
      end
    end
  end
endmodule

//--- verif/sdram_asserts.sv
module sdram_asserts (
  input logic clk,
  input logic reset,
  input logic ready,
  input logic available,
  input logic init_complete,
  input logic dq_oe,
  input logic rd_beat
);
  timeunit 1ns;
  timeprecision 100ps;

  ready_single: assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
    else $error("ready high for more than one cycle");

  avail_after_init: assert property (@(posedge clk) disable iff (reset)
    available |-> init_complete)
    else $error("available high before init_complete");

  // Write data holds the bus for a single cycle
  dq_single: assert property (@(posedge clk) disable iff (reset) dq_oe |=> !dq_oe)
    else $error("data bus driven for more than one cycle");

  // Never drive while the part returns read data
  dq_no_contention: assert property (@(posedge clk) disable iff (reset)
    dq_oe |-> !rd_beat)
    else $error("data bus driven while read data is due");
endmodule

bind sdram_ctrl sdram_asserts i_asserts (
  .clk(clk), .reset(reset), .ready(ready), .available(available),
  .init_complete(init_complete), .dq_oe(i_pin_driver.dq_oe),
  .rd_beat(i_read_capture.beat)
);

//--- verif/tb_sdram.sv
module tb_sdram
  import sdram_cmd_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic init_complete, available, ready;
  logic [addr_width-1:0] addr = '0;
  logic [data_width-1:0] wr_data = '0;
  logic [1:0] byte_en = '0;
  logic wr_req = 1'b0;
  logic rd_req = 1'b0;
  logic [rd_data_width-1:0] rd_data;
  wire  [data_width-1:0] sdram_dq;
  logic [row_width-1:0] sdram_a;
  logic [bank_width-1:0] sdram_ba;
  logic [1:0] sdram_dqm;
  logic sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n, sdram_cke;
  int error_count, read_count, refresh_count;
  int tb_errors = 0;
  int tests = 0;
  int err_mark = 0;
  int active_count = 0;
  int seed = 81;
  int steps[$];
  logic cke_seen = 1'b0;

  always #5 clk = ~clk;

  sdram_ctrl i_dut (.*);

  sdram_model i_model (
    .clk(clk), .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n),
    .cas_n(sdram_cas_n), .we_n(sdram_we_n), .ba(sdram_ba), .a(sdram_a),
    .dqm(sdram_dqm), .dq(sdram_dq)
  );

  sdram_checker i_checker (
    .clk(clk), .reset(reset), .init_complete(init_complete), .addr(addr),
    .wr_data(wr_data), .byte_en(byte_en), .wr_req(wr_req), .rd_req(rd_req),
    .available(available), .ready(ready), .rd_data(rd_data), .cs_n(sdram_cs_n),
    .ras_n(sdram_ras_n), .cas_n(sdram_cas_n), .we_n(sdram_we_n),
    .error_count(error_count), .read_count(read_count), .refresh_count(refresh_count)
  );

  ////////////////////////////////////////
  // Pin command log
  // Power-up codes: 1 CKE, 2 precharge-all, 3 refresh, 4 load mode, 9 wrong
  always @(posedge clk) begin
    if (!reset && !init_complete) begin
      if (sdram_cke && !cke_seen) begin
        steps.push_back(1);
        cke_seen = 1'b1;
      end
      case ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n})
        4'b0111, 4'b1111: ;
        4'b0010: steps.push_back(sdram_a[10] ? 2 : 9);
        4'b0001: steps.push_back(3);
        4'b0000: steps.push_back((sdram_a == mode_word && sdram_ba == '0) ? 4 : 9);
        default: steps.push_back(9);
      endcase
    end
    if ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} == 4'b0011) begin
      active_count++;
    end
  end

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic wait_init();
    int n;
    n = 0;
    while (!init_complete && n < 2000) begin
      @(posedge clk);
      n++;
    end
    if (!init_complete) abort_run("init_complete");
  endtask

  // Hold the request until it is taken, then release it
  task automatic start_request(input logic wr, input logic [addr_width-1:0] a,
                               input logic [data_width-1:0] d, input logic [1:0] be);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    wr_req = wr;
    rd_req = !wr;
    addr = a;
    wr_data = d;
    byte_en = be;
    do begin
      @(posedge clk);
      n++;
    end while (!available && n < 100);
    if (!available) abort_run("available");
    #1;
    wr_req = 1'b0;
    rd_req = 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!ready && n < 100);
    if (!ready) abort_run("ready");
  endtask

  task automatic request(input logic wr, input logic [addr_width-1:0] a,
                         input logic [data_width-1:0] d, input logic [1:0] be);
    start_request(wr, a, d, be);
    wait_ready();
  endtask

  task automatic end_test(input string name);
    int errs;
    // Checker compares on the same edge that ended the test
    #1;
    errs = tb_errors + error_count - err_mark;
    tests++;
    $display("Test %0d %s: %0d errors", tests, name, errs);
    err_mark = tb_errors + error_count;
  endtask

  initial begin
    int exp_steps[5];
    int act_before;
    int ref_before;
    logic [addr_width-1:0] a;
    logic wr;
    exp_steps = '{1, 2, 3, 3, 4};
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // Power-up
    wait_init();
    if (steps.size() != 5) begin
      $display("Power-up showed %0d commands instead of 5", steps.size());
      tb_errors++;
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (steps[i] != exp_steps[i]) begin
          $display("FAIL %0t powerup_step%0d expected %0d actual %0d",
                   $time, i, exp_steps[i], steps[i]);
          tb_errors++;
        end
      end
    end
    start_request(1'b0, 25'h0, '0, 2'b00);
    wait_ready();
    end_test("power-up");

    // Write a pair, read both columns
    a = {2'd1, 13'd5, 10'd8};
    request(1'b1, a, 16'h1234, 2'b11);
    request(1'b1, a + 1, 16'habcd, 2'b11);
    request(1'b0, a, '0, 2'b00);
    request(1'b0, a + 1, '0, 2'b00);
    end_test("write then read");

    // Low byte only
    request(1'b1, a, 16'h77ee, 2'b01);
    request(1'b0, a, '0, 2'b00);
    request(1'b1, a + 1, 16'h5511, 2'b10);
    request(1'b0, a + 1, '0, 2'b00);
    end_test("byte enables");

    // Refresh while idle and under traffic
    ref_before = refresh_count;
    repeat (1600) @(posedge clk);
    if (refresh_count - ref_before < 2) begin
      $display("Only %0d auto refreshes during idle", refresh_count - ref_before);
      tb_errors++;
    end
    for (int i = 0; i < 120; i++) begin
      request(1'b0, a + (i % 2), '0, 2'b00);
    end
    end_test("refresh");

    // Request raised while busy is ignored
    act_before = active_count;
    start_request(1'b1, a, 16'h4242, 2'b11);
    wr_req = 1'b1;
    addr = a + 1;
    wr_data = 16'hdead;
    byte_en = 2'b11;
    repeat (3) begin
      @(posedge clk);
      if (available) begin
        $display("available high during a write at %0t", $time);
        tb_errors++;
      end
      #1;
    end
    wr_req = 1'b0;
    wait_ready();
    if (active_count - act_before != 1) begin
      $display("FAIL %0t active_count expected 1 actual %0d", $time,
               active_count - act_before);
      tb_errors++;
    end
    request(1'b0, a + 1, '0, 2'b00);
    end_test("back-pressure");

    // Random traffic over a small window
    for (int i = 0; i < 60; i++) begin
      wr = 1'($random(seed));
      a = {2'($random(seed)), 13'($random(seed) & 1), 10'($random(seed) & 7)};
      request(wr, a, 16'($random(seed)), 2'($random(seed)));
    end
    end_test("random traffic");

    $display("Tests %0d, reads checked %0d, errors %0d", tests, read_count,
             tb_errors + error_count);
    if (tb_errors + error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end
endmodule

//--- vlog.f
common/sdram_timing_pkg.sv
common/sdram_cmd_pkg.sv
common/sdram_cmd_if.sv
sdram/sdram_sequencer.sv
sdram/sdram_pin_driver.sv
sdram/sdram_read_capture.sv
sdram/sdram_ctrl.sv
verif/sdram_model.sv
verif/sdram_checker.sv
verif/sdram_asserts.sv
verif/tb_sdram.sv

//--- Makefile
TOP = tb_sdram

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
